//--- hw/mipsPkg.sv
package mipsPkg;

	////////////////////////////////////////////////////////////
	// widths fixed by the ISA
	////////////////////////////////////////////////////////////

	// data and instruction word
	typedef logic [31:0] wordT;
	// one of 32 registers
	typedef logic [4:0] regAddrT;
	// low six bits of an R-type word
	typedef logic [5:0] functT;

	////////////////////////////////////////////////////////////
	// alu operations
	////////////////////////////////////////////////////////////

	// aluNone marks an instruction that never reaches execute
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt,
		aluSll, aluSrl, aluSra,
		aluNone
	} aluOpT;

	// funct codes of the supported R-type instructions
	localparam functT functSll = 6'h00;
	localparam functT functSrl = 6'h02;
	localparam functT functSra = 6'h03;
	localparam functT functAdd = 6'h20;
	localparam functT functSub = 6'h22;
	localparam functT functAnd = 6'h24;
	localparam functT functOr  = 6'h25;
	localparam functT functXor = 6'h26;
	localparam functT functNor = 6'h27;
	localparam functT functSlt = 6'h2a;

	// every R-type word carries opcode zero
	localparam logic [5:0] opRtype = 6'h00;

endpackage

//--- hw/mipsController.sv
`timescale 1ns/1ns

module mipsController (
	input  logic       clk,
	input  logic       rst,
	input  logic       instrValid,
	input  logic       wbReady,
	input  logic       illegal,
	input  logic [5:0] opcode,
	output logic       instrReady,
	output logic       execEnable,
	output logic       wbValid,
	output logic       regWrite
);

	// one state per step of the multicycle sequence
	typedef enum logic [1:0] {
		fetch,
		decode,
		execute,
		writeBack
	} stateT;

	stateT state;
	stateT nextState;

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			// wait for the host to offer a word
			fetch: begin
				if (instrValid) begin
					nextState = decode;
				end
			end
			// non R-type or unknown funct is dropped here
			decode: begin
				if ((opcode != mipsPkg::opRtype) || illegal) begin
					nextState = fetch;
				end else begin
					nextState = execute;
				end
			end
			// result register loads this cycle
			execute: begin
				nextState = writeBack;
			end
			// hold until the sink takes the write-back
			writeBack: begin
				if (wbReady) begin
					nextState = fetch;
				end
			end
			default: begin
				nextState = fetch;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// state and registered outputs
	////////////////////////////////////////////////////////////

	// outputs follow the state they are entering
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= fetch;
			instrReady <= 1'b1;
			execEnable <= 1'b0;
			wbValid    <= 1'b0;
		end else begin
			state      <= nextState;
			instrReady <= (nextState == fetch);
			execEnable <= (nextState == execute);
			wbValid    <= (nextState == writeBack);
		end
	end

	// register write happens exactly on the write-back transfer
	assign regWrite = wbValid && wbReady;

	// each registered output marks its own state
	stateOutputs: assert property (@(posedge clk) disable iff (rst)
		(instrReady == (state == fetch)) && (execEnable == (state == execute))
		&& (wbValid == (state == writeBack)));

	// a stalled write-back is never withdrawn
	wbHeld: assert property (@(posedge clk) disable iff (rst)
		wbValid && !wbReady |=> wbValid);

endmodule

//--- hw/aluDecoder.sv
`timescale 1ns/1ns

module aluDecoder (
	input  mipsPkg::functT funct,
	output mipsPkg::aluOpT aluOp,
	output logic           illegal
);

	// R-type only, so funct alone picks the operation
	always_comb begin
		illegal = 1'b0;
		case (funct)
			// arithmetic that wraps on overflow
			mipsPkg::functAdd: aluOp = mipsPkg::aluAdd;
			mipsPkg::functSub: aluOp = mipsPkg::aluSub;
			// bitwise logic
			mipsPkg::functAnd: aluOp = mipsPkg::aluAnd;
			mipsPkg::functOr:  aluOp = mipsPkg::aluOr;
			mipsPkg::functXor: aluOp = mipsPkg::aluXor;
			mipsPkg::functNor: aluOp = mipsPkg::aluNor;
			// signed compare
			mipsPkg::functSlt: aluOp = mipsPkg::aluSlt;
			// shifts by shamt
			mipsPkg::functSll: aluOp = mipsPkg::aluSll;
			mipsPkg::functSrl: aluOp = mipsPkg::aluSrl;
			mipsPkg::functSra: aluOp = mipsPkg::aluSra;
			// anything else gets dropped in decode
			default: begin
				aluOp   = mipsPkg::aluNone;
				illegal = 1'b1;
			end
		endcase
	end

endmodule

//--- hw/registerFile.sv
`timescale 1ns/1ns

module registerFile (
	input  logic             clk,
	input  logic             rst,
	input  mipsPkg::regAddrT raddrA,
	input  mipsPkg::regAddrT raddrB,
	output mipsPkg::wordT    rdataA,
	output mipsPkg::wordT    rdataB,
	input  logic             we,
	input  mipsPkg::regAddrT waddr,
	input  mipsPkg::wordT    wdata,
	input  logic             hostWe,
	input  mipsPkg::regAddrT hostAddr,
	input  mipsPkg::wordT    hostData
);

	mipsPkg::wordT regs [32];

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////

	// core write wins over the host port
	// register zero is never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			if (waddr != '0) begin
				regs[waddr] <= wdata;
			end
		end else if (hostWe) begin
			if (hostAddr != '0) begin
				regs[hostAddr] <= hostData;
			end
		end
	end

	// asynchronous reads for rs and rt
	assign rdataA = regs[raddrA];
	assign rdataB = regs[raddrB];

	// zero stays zero whichever port writes it
	zeroReg: assert property (@(posedge clk) disable iff (rst)
		regs[0] == '0);

endmodule

//--- hw/aluExecute.sv
`timescale 1ns/1ns

module aluExecute (
	input  logic           clk,
	input  logic           rst,
	input  logic           enable,
	input  mipsPkg::aluOpT aluOp,
	input  mipsPkg::wordT  opA,
	input  mipsPkg::wordT  opB,
	input  logic [4:0]     shamt,
	output mipsPkg::wordT  result
);

	mipsPkg::wordT aluOut;

	////////////////////////////////////////////////////////////
	// combinational alu
	////////////////////////////////////////////////////////////

	always_comb begin
		case (aluOp)
			// plain 32-bit wrap without a trap
			mipsPkg::aluAdd: aluOut = opA + opB;
			mipsPkg::aluSub: aluOut = opA - opB;
			mipsPkg::aluAnd: aluOut = opA & opB;
			mipsPkg::aluOr:  aluOut = opA | opB;
			mipsPkg::aluXor: aluOut = opA ^ opB;
			mipsPkg::aluNor: aluOut = ~(opA | opB);
			// signed compare giving 0 or 1
			mipsPkg::aluSlt: aluOut = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
			// shifts act on rt only
			mipsPkg::aluSll: aluOut = opB << shamt;
			mipsPkg::aluSrl: aluOut = opB >> shamt;
			// arithmetic shift keeps the sign
			mipsPkg::aluSra: aluOut = $signed(opB) >>> shamt;
			default:         aluOut = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// result register
	////////////////////////////////////////////////////////////

	// loads in execute and holds through write-back stalls
	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
		end else if (enable) begin
			result <= aluOut;
		end
	end

	// decode must have dropped anything without an operation
	noExecNone: assert property (@(posedge clk) disable iff (rst)
		enable |-> aluOp != mipsPkg::aluNone);

endmodule

//--- hw/mipsRtypeCore.sv
`timescale 1ns/1ns

module mipsRtypeCore (
	input  logic             clk,
	input  logic             rst,
	input  logic             instrValid,
	input  mipsPkg::wordT    instr,
	output logic             instrReady,
	output logic             wbValid,
	output mipsPkg::regAddrT wbAddr,
	output mipsPkg::wordT    wbData,
	input  logic             wbReady,
	input  logic             hostWe,
	input  mipsPkg::regAddrT hostAddr,
	input  mipsPkg::wordT    hostData
);

	mipsPkg::wordT    instrReg;
	mipsPkg::wordT    rdataA;
	mipsPkg::wordT    rdataB;
	mipsPkg::functT   funct;
	mipsPkg::aluOpT   aluOp;
	mipsPkg::regAddrT rs;
	mipsPkg::regAddrT rt;
	logic [5:0]       opcode;
	logic [4:0]       shamt;
	logic             illegal;
	logic             execEnable;
	logic             regWrite;

	////////////////////////////////////////////////////////////
	// instruction register and fields
	////////////////////////////////////////////////////////////

	// latched on the handshake and held until the next accept
	always_ff @(posedge clk) begin
		if (instrValid && instrReady) begin
			instrReg <= instr;
		end
	end

	assign opcode = instrReg[31:26];
	assign rs     = instrReg[25:21];
	assign rt     = instrReg[20:16];
	// rd goes straight out as the write-back address
	assign wbAddr = instrReg[15:11];
	assign shamt  = instrReg[10:6];
	assign funct  = instrReg[5:0];

	////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////

	mipsController ctrl (.clk(clk), .rst(rst), .instrValid(instrValid), .wbReady(wbReady),
		.illegal(illegal), .opcode(opcode), .instrReady(instrReady),
		.execEnable(execEnable), .wbValid(wbValid), .regWrite(regWrite));

	// decoder and register file work side by side in decode
	aluDecoder dec (.funct(funct), .aluOp(aluOp), .illegal(illegal));

	registerFile regFile (.clk(clk), .rst(rst), .raddrA(rs), .raddrB(rt),
		.rdataA(rdataA), .rdataB(rdataB), .we(regWrite), .waddr(wbAddr),
		.wdata(wbData), .hostWe(hostWe), .hostAddr(hostAddr), .hostData(hostData));

	aluExecute exec (.clk(clk), .rst(rst), .enable(execEnable), .aluOp(aluOp),
		.opA(rdataA), .opB(rdataB), .shamt(shamt), .result(wbData));

endmodule

//--- testbench/mipsRtypeCoreTb.sv
`timescale 1ns/1ns

module mipsRtypeCoreTb;

	localparam int clkPeriod = 100;
	localparam int cyclesPerLine = 40;

	logic             clk;
	logic             rst;
	logic             instrValid;
	mipsPkg::wordT    instr;
	logic             instrReady;
	logic             wbValid;
	mipsPkg::regAddrT wbAddr;
	mipsPkg::wordT    wbData;
	logic             wbReady;
	logic             hostWe;
	mipsPkg::regAddrT hostAddr;
	mipsPkg::wordT    hostData;

	integer seed;
	int     lineCount;
	logic   watchdogArmed;
	int     checkCount;
	int     valueErrors;
	int     timingErrors;

	mipsRtypeCore uut (.clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
		.instrReady(instrReady), .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
		.wbReady(wbReady), .hostWe(hostWe), .hostAddr(hostAddr), .hostData(hostData));

	////////////////////////////////////////////////////////////
	// clock and back-pressure
	////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// sink stalls about one cycle in four
	always @(posedge clk) begin
		wbReady <= (($random(seed) & 3) != 0);
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	task automatic checkWriteBack(input mipsPkg::regAddrT gotAddr, input mipsPkg::wordT gotData,
		input mipsPkg::regAddrT expAddr, input mipsPkg::wordT expData);
		checkCount++;
		if (gotAddr !== expAddr || gotData !== expData) begin
			valueErrors++;
			$display("CHECK FAILED at %0t: write-back r%0d = %h, expected r%0d = %h",
				$time, gotAddr, gotData, expAddr, expData);
		end
	endtask

	task automatic checkCycles(input int got, input int exp, input string what);
		checkCount++;
		if (got != exp) begin
			timingErrors++;
			$display("CHECK FAILED at %0t: %s after %0d cycles, expected %0d",
				$time, what, got, exp);
		end
	endtask

	task automatic checkLevel(input logic got, input logic exp, input string what);
		checkCount++;
		if (got !== exp) begin
			timingErrors++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic reportMalformed(input logic [7:0] kind);
		valueErrors++;
		$display("stimulus line of kind %s has the wrong number of fields", kind);
	endtask

	////////////////////////////////////////////////////////////
	// host side sequences
	////////////////////////////////////////////////////////////

	// R-type layout is opcode rs rt rd shamt funct
	function automatic mipsPkg::wordT packInstr(input logic [31:0] op, input logic [31:0] rs,
		input logic [31:0] rt, input logic [31:0] rd, input logic [31:0] sh,
		input logic [31:0] fn);
		return {op[5:0], rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn[5:0]};
	endfunction

	task automatic hostLoad(input mipsPkg::regAddrT addr, input mipsPkg::wordT value);
		@(posedge clk);
		hostWe   <= 1'b1;
		hostAddr <= addr;
		hostData <= value;
		// register loads on this edge
		@(posedge clk);
		checkLevel(instrReady, 1'b1, "instrReady during host load");
		hostWe <= 1'b0;
	endtask

	// returns on the acceptance edge
	task automatic acceptInstr(input mipsPkg::wordT word);
		@(posedge clk);
		instrValid <= 1'b1;
		instr      <= word;
		@(posedge clk);
		while (!instrReady) begin
			@(posedge clk);
		end
		instrValid <= 1'b0;
	endtask

	task automatic runWriteBack(input mipsPkg::wordT word, input mipsPkg::regAddrT expAddr,
		input mipsPkg::wordT expData);
		int               cycles;
		mipsPkg::regAddrT heldAddr;
		mipsPkg::wordT    heldData;
		acceptInstr(word);
		@(posedge clk);
		cycles = 1;
		while (!wbValid) begin
			@(posedge clk);
			cycles++;
		end
		checkCycles(cycles, 3, "wbValid");
		heldAddr = wbAddr;
		heldData = wbData;
		// stalled write-back must not move
		while (!wbReady) begin
			@(posedge clk);
			checkLevel(wbValid, 1'b1, "wbValid under stall");
			checkWriteBack(wbAddr, wbData, heldAddr, heldData);
		end
		checkWriteBack(heldAddr, heldData, expAddr, expData);
		// one transfer only and then back to fetch
		@(posedge clk);
		checkLevel(wbValid, 1'b0, "wbValid after transfer");
		checkLevel(instrReady, 1'b1, "instrReady after transfer");
	endtask

	task automatic checkDropped(input mipsPkg::wordT word);
		int cycles;
		acceptInstr(word);
		@(posedge clk);
		cycles = 1;
		checkLevel(wbValid, 1'b0, "wbValid on dropped instruction");
		while (!instrReady) begin
			@(posedge clk);
			cycles++;
			checkLevel(wbValid, 1'b0, "wbValid on dropped instruction");
		end
		checkCycles(cycles, 2, "instrReady after drop");
	endtask

	////////////////////////////////////////////////////////////
	// watchdog
	////////////////////////////////////////////////////////////

	initial begin
		wait (watchdogArmed);
		#(lineCount * cyclesPerLine * clkPeriod);
		$display("timeout: the core stopped responding before the stimulus file was finished");
		$display("TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int               fd;
		int               n;
		logic [7:0]       kind;
		logic [8*256-1:0] line;
		logic [31:0]      opF;
		logic [31:0]      rsF;
		logic [31:0]      rtF;
		logic [31:0]      rdF;
		logic [31:0]      shF;
		logic [31:0]      fnF;
		logic [31:0]      expAddrF;
		logic [31:0]      expDataF;
		seed          = 32'h1e68_68bc;
		rst           = 1'b1;
		instrValid    = 1'b0;
		instr         = '0;
		wbReady       = 1'b0;
		hostWe        = 1'b0;
		hostAddr      = '0;
		hostData      = '0;
		lineCount     = 0;
		watchdogArmed = 1'b0;
		checkCount    = 0;
		valueErrors   = 0;
		timingErrors  = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		checkLevel(instrReady, 1'b1, "instrReady after reset");
		checkLevel(wbValid, 1'b0, "wbValid after reset");
		fd = $fopen("testbench/rtypeStimulus.dat", "r");
		if (fd == 0) begin
			$display("could not open testbench/rtypeStimulus.dat");
			$display("TESTS FAILED");
			$finish;
		end else begin
			// first pass only sizes the watchdog
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0) begin
					lineCount++;
				end
			end
			$fclose(fd);
			watchdogArmed = 1'b1;
			fd = $fopen("testbench/rtypeStimulus.dat", "r");
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", kind);
				if (n == 1) begin
					if (kind == "#") begin
						n = $fgets(line, fd);
					end else if (kind == "L") begin
						n = $fscanf(fd, "%h %h", rdF, expDataF);
						if (n != 2) reportMalformed(kind);
						else hostLoad(rdF[4:0], expDataF);
					end else if (kind == "I") begin
						n = $fscanf(fd, "%h %h %h %h %h %h %h %h",
							opF, rsF, rtF, rdF, shF, fnF, expAddrF, expDataF);
						if (n != 8) reportMalformed(kind);
						else runWriteBack(packInstr(opF, rsF, rtF, rdF, shF, fnF),
							expAddrF[4:0], expDataF);
					end else if (kind == "D") begin
						n = $fscanf(fd, "%h %h %h %h %h %h", opF, rsF, rtF, rdF, shF, fnF);
						if (n != 6) reportMalformed(kind);
						else checkDropped(packInstr(opF, rsF, rtF, rdF, shF, fnF));
					end else begin
						reportMalformed(kind);
					end
				end
			end
			$fclose(fd);
			$display("checks %0d, value errors %0d, timing errors %0d",
				checkCount, valueErrors, timingErrors);
			if (valueErrors + timingErrors == 0) begin
				$display("TESTS PASSED");
			end else begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

//--- testbench/rtypeStimulus.dat
# L addr value | I op rs rt rd shamt funct expRd expValue | all fields hex
# D op rs rt rd shamt funct marks an instruction that must be dropped
L 1 00000007
L 2 00000005
L 3 7fffffff
L 4 00000001
L 5 80000000
L 6 f0f0f0f0
L 7 0ff00ff0
L 8 fffffff8
I 0 1 2 9 0 20 9 0000000c
I 0 3 4 a 0 20 a 80000000
I 0 1 2 b 0 22 b 00000002
I 0 5 4 c 0 22 c 7fffffff
I 0 6 7 d 0 24 d 00f000f0
I 0 6 7 e 0 25 e fff0fff0
I 0 6 7 f 0 26 f ff00ff00
I 0 6 7 10 0 27 10 000f000f
I 0 8 1 11 0 2a 11 00000001
I 0 1 8 12 0 2a 12 00000000
I 0 5 3 13 0 2a 13 00000001
I 0 0 1 14 4 00 14 00000070
I 0 0 6 15 4 02 15 0f0f0f0f
I 0 0 6 16 4 03 16 ff0f0f0f
I 0 0 5 17 1f 03 17 ffffffff
I 0 9 b 19 0 20 19 0000000e
I 0 1 2 0 0 20 0 0000000c
I 0 0 1 1b 0 20 1b 00000007
D 2 1 2 1d 0 20
D 0 1 2 1d 0 21
I 0 1d 0 1e 0 20 1e 00000000

//--- mipsRtypeCore.f
hw/mipsPkg.sv
hw/mipsController.sv
hw/aluDecoder.sv
hw/registerFile.sv
hw/aluExecute.sv
hw/mipsRtypeCore.sv
testbench/mipsRtypeCoreTb.sv

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module mipsRtypeCoreTb \
	-f mipsRtypeCore.f -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^TESTS PASSED$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
